/* common/periph_defines.svh */
`ifndef PERIPH_DEFINES_SVH
`define PERIPH_DEFINES_SVH

// soft spi corner of the board top

// one channel per lane of the board spi bus
`define NUM_SPI_CH 3

// sys_clk cycles per sclk half period
`define SPI_CLK_DIV 4

// sys_clk cycles between two 74hc595 frames
`define SEG_REFRESH_DIV 64

`endif

/* common/periph_pkg.sv */
package periph_pkg;

  typedef logic [1:0] ch_idx_t;     // channel number
  typedef logic [7:0] spi_byte_t;   // one spi data byte
  typedef logic [7:0] seg_pat_t;    // active low segment pattern with dp in bit 7

  typedef struct packed {
    ch_idx_t   ch;
    spi_byte_t data;
  } spi_cmd_t;

  typedef struct packed {
    ch_idx_t   ch;
    spi_byte_t data;
  } spi_resp_t;

  typedef enum logic [1:0] {
    IDLE,
    SETUP,
    SHIFT,
    DONE
  } spi_state_t;

  // common anode table with bit 0 as segment a
  function automatic seg_pat_t hex_to_seg(input logic [3:0] nib);
    case (nib)
      4'h0: return 8'hc0;
      4'h1: return 8'hf9;
      4'h2: return 8'ha4;
      4'h3: return 8'hb0;
      4'h4: return 8'h99;
      4'h5: return 8'h92;
      4'h6: return 8'h82;
      4'h7: return 8'hf8;
      4'h8: return 8'h80;
      4'h9: return 8'h90;
      4'ha: return 8'h88;
      4'hb: return 8'h83;
      4'hc: return 8'hc6;
      4'hd: return 8'ha1;
      4'he: return 8'h86;
      default: return 8'h8e;
    endcase
  endfunction

endpackage

/* softspi/spi_cmd_dispatch.sv */
`include "periph_defines.svh"

module spi_cmd_dispatch
  import periph_pkg::*;
(
  input  logic                   sys_clk,
  input  logic                   rst,
  input  spi_cmd_t               cmd,
  input  logic                   cmd_valid,
  output logic                   cmd_ready,
  input  logic [`NUM_SPI_CH-1:0] busy,
  output logic [`NUM_SPI_CH-1:0] go,
  output spi_byte_t              cmd_data
);

  logic                   armed;     // low during and right after reset
  logic                   in_range;  // channel field names a real channel
  logic [`NUM_SPI_CH-1:0] sel;       // one-hot target
  logic                   accept;

  assign in_range = (int'(cmd.ch) < `NUM_SPI_CH);

  always_comb begin
    sel = '0;
    if (in_range) begin
      sel[cmd.ch] = 1'b1;
    end
  end

  // out of range commands are always taken and simply vanish
  assign cmd_ready = armed & (~in_range | ~|(busy & sel));
  assign accept    = cmd_valid & cmd_ready;
  assign go        = accept ? sel : '0;

  always_ff @(posedge sys_clk) begin
    if (rst) begin
      armed <= 1'b0;
    end else begin
      armed <= 1'b1;
    end
  end

  // shared byte picked up by the channel in its first setup cycle
  always_ff @(posedge sys_clk) begin
    if (accept) begin
      cmd_data <= cmd.data;
    end
  end

endmodule

/* softspi/spi_channel.sv */
`include "periph_defines.svh"

module spi_channel
  import periph_pkg::*;
(
  input  logic      sys_clk,
  input  logic      rst,
  input  logic      go,
  input  spi_byte_t cmd_data,
  output logic      busy,
  output logic      res_valid,
  output spi_byte_t res_data,
  input  logic      res_ready,
  output logic      sclk,
  output logic      mosi,
  output logic      ncs,
  input  logic      miso
);

  localparam int HC_W = $clog2(`SPI_CLK_DIV + 1);

  spi_state_t      state;
  logic [HC_W-1:0] half_cnt;  // sys_clk cycles inside the half period
  logic [3:0]      bit_cnt;   // rising edges seen so far
  spi_byte_t       shreg;     // tx bits out the top, rx bits in the bottom
  logic            half_end;
  logic            load;      // first setup cycle
  logic            rise;
  logic            fall;
  logic            last;      // end of the eighth period

  assign half_end = (half_cnt == HC_W'(`SPI_CLK_DIV - 1));
  assign load     = (state == SETUP) && (half_cnt == '0);

  // setup doubles as the low half before the first rising edge
  assign rise = half_end && ((state == SETUP) ||
                ((state == SHIFT) && !sclk && (bit_cnt != 4'd8)));
  assign fall = half_end && (state == SHIFT) && sclk;
  assign last = half_end && (state == SHIFT) && !sclk && (bit_cnt == 4'd8);

  always_ff @(posedge sys_clk) begin
    if (rst) begin
      state    <= IDLE;
      half_cnt <= '0;
      bit_cnt  <= '0;
      sclk     <= 1'b0;
      mosi     <= 1'b0;
      ncs      <= 1'b1;
    end else begin
      if (((state == SETUP) || (state == SHIFT)) && !half_end) begin
        half_cnt <= half_cnt + 1'b1;
      end else begin
        half_cnt <= '0;
      end

      case (state)
        IDLE: begin
          bit_cnt <= '0;
          if (go) begin
            state <= SETUP;
            ncs   <= 1'b0;  // select on the edge after go
          end
        end
        SETUP: begin
          if (load) begin
            mosi <= cmd_data[7];  // msb ahead of the first rising edge
          end
          if (rise) begin
            sclk    <= 1'b1;
            bit_cnt <= bit_cnt + 1'b1;
            state   <= SHIFT;
          end
        end
        SHIFT: begin
          if (fall) begin
            sclk <= 1'b0;
            mosi <= (bit_cnt == 4'd8) ? 1'b0 : shreg[7];
          end else if (rise) begin
            sclk    <= 1'b1;
            bit_cnt <= bit_cnt + 1'b1;
          end else if (last) begin
            ncs   <= 1'b1;
            state <= DONE;
          end
        end
        DONE: begin
          if (res_ready) begin
            state <= IDLE;  // handoff to the collector
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge sys_clk) begin
    if (load) begin
      shreg <= cmd_data;
    end else if (rise) begin
      shreg <= {shreg[6:0], miso};  // sample on the rising edge
    end
  end

  assign busy      = (state != IDLE);
  assign res_valid = (state == DONE);
  assign res_data  = shreg;

endmodule

/* softspi/spi_resp_collect.sv */
`include "periph_defines.svh"

module spi_resp_collect
  import periph_pkg::*;
(
  input  logic                              sys_clk,
  input  logic                              rst,
  input  logic      [`NUM_SPI_CH-1:0]       res_valid,
  input  spi_byte_t [`NUM_SPI_CH-1:0]       res_data,
  output logic      [`NUM_SPI_CH-1:0]       res_ready,
  output spi_resp_t                         resp,
  output logic                              resp_valid,
  input  logic                              resp_ready,
  output logic      [31:0]                  history
);

  ch_idx_t last;     // channel granted most recently
  ch_idx_t grant;
  logic    found;
  logic    hold;     // offer stalled by resp_ready
  ch_idx_t hold_ch;  // channel of the stalled offer

  // search from last+1 onward so the nearest pending channel wins
  always_comb begin
    int j;
    grant = last;
    found = 1'b0;
    for (int i = `NUM_SPI_CH; i >= 1; i--) begin
      j = (int'(last) + i) % `NUM_SPI_CH;
      if (res_valid[j]) begin
        grant = ch_idx_t'(j);
        found = 1'b1;
      end
    end
    if (hold) begin
      grant = hold_ch;  // a stalled offer stays put
      found = res_valid[hold_ch];
    end
  end

  assign resp_valid = found;
  assign resp.ch    = grant;
  assign resp.data  = res_data[grant];

  always_comb begin
    res_ready = '0;
    if (found && resp_ready) begin
      res_ready[grant] = 1'b1;  // back-pressure goes straight through
    end
  end

  always_ff @(posedge sys_clk) begin
    if (rst) begin
      last    <= ch_idx_t'(`NUM_SPI_CH - 1);  // channel 0 goes first
      hold    <= 1'b0;
      hold_ch <= '0;
      history <= '0;
    end else if (resp_valid && resp_ready) begin
      last    <= grant;
      hold    <= 1'b0;
      history <= {history[23:0], resp.data};  // newest byte at the bottom
    end else if (resp_valid) begin
      hold    <= 1'b1;
      hold_ch <= grant;
    end
  end

endmodule

/* source/seg_led_hex595.sv */
`include "periph_defines.svh"

module seg_led_hex595
  import periph_pkg::*;
(
  input  logic        sys_clk,
  input  logic        rst,
  input  logic [31:0] data,
  output logic        clk,
  output logic        dat,
  output logic        str
);

  localparam int RC_W = $clog2(`SEG_REFRESH_DIV + 1);

  logic [RC_W-1:0] ref_cnt;
  logic [2:0]      digit;    // digit sent in the next frame
  logic [5:0]      step;     // two steps per bit, then the strobe
  logic            sending;
  logic [15:0]     shreg;    // segment byte on top of the select byte
  logic            frame_start;
  seg_pat_t        seg;
  logic [7:0]      sel;

  assign frame_start = (ref_cnt == RC_W'(`SEG_REFRESH_DIV - 1));
  assign seg         = hex_to_seg(data[{digit, 2'b00} +: 4]);
  assign sel         = 8'b1 << digit;  // one-hot, active high

  always_ff @(posedge sys_clk) begin
    if (rst) begin
      ref_cnt <= '0;
      digit   <= '0;
      step    <= '0;
      sending <= 1'b0;
      clk     <= 1'b0;
      dat     <= 1'b0;
      str     <= 1'b0;
    end else begin
      ref_cnt <= frame_start ? '0 : ref_cnt + 1'b1;
      str     <= 1'b0;
      if (!sending) begin
        if (frame_start) begin
          sending <= 1'b1;
          step    <= '0;
          digit   <= digit + 1'b1;
        end
      end else begin
        step <= step + 1'b1;
        if (step < 6'd32) begin
          if (!step[0]) begin
            clk <= 1'b0;
            dat <= shreg[15];  // data moves while clk is low
          end else begin
            clk <= 1'b1;       // one cycle high per bit
          end
        end else if (step == 6'd32) begin
          clk <= 1'b0;
          str <= 1'b1;         // latch the 595 outputs
        end else begin
          sending <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge sys_clk) begin
    if (!sending && frame_start) begin
      shreg <= {seg, sel};
    end else if (sending && step[0] && (step < 6'd32)) begin
      shreg <= {shreg[14:0], 1'b0};
    end
  end

endmodule

/* source/periph_top.sv */
`include "periph_defines.svh"

module periph_top
  import periph_pkg::*;
(
  input  logic                   sys_clk,
  input  logic                   rst,

  input  spi_cmd_t               cmd,
  input  logic                   cmd_valid,
  output logic                   cmd_ready,

  output spi_resp_t              resp,
  output logic                   resp_valid,
  input  logic                   resp_ready,

  input  logic [`NUM_SPI_CH-1:0] spi_miso,
  output logic [`NUM_SPI_CH-1:0] spi_mosi,
  output logic [`NUM_SPI_CH-1:0] spi_sclk,
  output logic [`NUM_SPI_CH-1:0] spi_cs,   // active low

  output logic                   segled_clk,
  output logic                   segled_dat,
  output logic                   segled_str
);

  logic      [`NUM_SPI_CH-1:0] busy;
  logic      [`NUM_SPI_CH-1:0] go;
  spi_byte_t                   cmd_data;
  logic      [`NUM_SPI_CH-1:0] res_valid;
  logic      [`NUM_SPI_CH-1:0] res_ready;
  spi_byte_t [`NUM_SPI_CH-1:0] res_data;
  logic      [31:0]            history;   // last four response bytes

  spi_cmd_dispatch u_dispatch (
    .sys_clk   (sys_clk),
    .rst       (rst),
    .cmd       (cmd),
    .cmd_valid (cmd_valid),
    .cmd_ready (cmd_ready),
    .busy      (busy),
    .go        (go),
    .cmd_data  (cmd_data)
  );

  for (genvar i = 0; i < `NUM_SPI_CH; i++) begin : g_ch
    spi_channel u_channel (
      .sys_clk   (sys_clk),
      .rst       (rst),
      .go        (go[i]),
      .cmd_data  (cmd_data),
      .busy      (busy[i]),
      .res_valid (res_valid[i]),
      .res_data  (res_data[i]),
      .res_ready (res_ready[i]),
      .sclk      (spi_sclk[i]),
      .mosi      (spi_mosi[i]),
      .ncs       (spi_cs[i]),
      .miso      (spi_miso[i])
    );
  end

  spi_resp_collect u_collect (
    .sys_clk    (sys_clk),
    .rst        (rst),
    .res_valid  (res_valid),
    .res_data   (res_data),
    .res_ready  (res_ready),
    .resp       (resp),
    .resp_valid (resp_valid),
    .resp_ready (resp_ready),
    .history    (history)
  );

  seg_led_hex595 u_seg_led_hex595 (
    .sys_clk (sys_clk),
    .rst     (rst),
    .data    (history),
    .clk     (segled_clk),
    .dat     (segled_dat),
    .str     (segled_str)
  );

endmodule

/* sim/periph_props.sv */
`include "periph_defines.svh"

module periph_props
  import periph_pkg::*;
(
  input logic                   sys_clk,
  input logic                   rst,
  input spi_cmd_t               cmd,
  input logic                   cmd_valid,
  input logic                   cmd_ready,
  input spi_resp_t              resp,
  input logic                   resp_valid,
  input logic                   resp_ready,
  input logic [`NUM_SPI_CH-1:0] spi_cs
);

  timeunit 1ns;
  timeprecision 100ps;

  // payload held while the sink stalls
  cmd_stable_a: assert property (@(posedge sys_clk) disable iff (rst)
    cmd_valid && !cmd_ready |=> cmd_valid && $stable(cmd))
    else $error("cmd changed while stalled");

  resp_stable_a: assert property (@(posedge sys_clk) disable iff (rst)
    resp_valid && !resp_ready |=> resp_valid && $stable(resp))
    else $error("resp changed while stalled");

  // one command per cycle starts at most one transfer
  cs_fall_a: assert property (@(posedge sys_clk) disable iff (rst)
    $countones($past(spi_cs) & ~spi_cs) <= 1)
    else $error("several chip selects fell together");

  reset_quiet_a: assert property (@(posedge sys_clk)
    rst |=> !cmd_ready && !resp_valid)
    else $error("handshake active during reset");

endmodule

bind periph_top periph_props u_props (
  .sys_clk    (sys_clk),
  .rst        (rst),
  .cmd        (cmd),
  .cmd_valid  (cmd_valid),
  .cmd_ready  (cmd_ready),
  .resp       (resp),
  .resp_valid (resp_valid),
  .resp_ready (resp_ready),
  .spi_cs     (spi_cs)
);

/* sim/periph_tb.sv */
`include "periph_defines.svh"

module periph_tb
  import periph_pkg::*;
;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int NCH = `NUM_SPI_CH;
  localparam int MAXL = 64;

  logic sys_clk, rst, cmd_valid, resp_ready, cmd_ready, resp_valid;
  spi_cmd_t  cmd;
  spi_resp_t resp, resp_prev;
  logic [NCH-1:0] spi_miso, spi_mosi, spi_sclk, spi_cs;
  logic [NCH-1:0] sclk_d, cs_d;
  logic segled_clk, segled_dat, segled_str, seg_clk_d, seg_str_d;

  logic [1:0] ch_v [MAXL];    // file columns
  logic [7:0] mosi_v [MAXL];
  logic [7:0] miso_v [MAXL];
  int         stall_v [MAXL];
  int nlines, n_exp, resp_cnt, errors, frame_cnt, stall_total, stall_used;
  int chan_line [NCH][MAXL];  // line index per channel in command order
  int wr [NCH];
  int sl_rd [NCH];
  int rsp_rd [NCH];
  int cur_ln [NCH];
  int bitn [NCH];
  logic [7:0] tx [NCH];
  logic [7:0] rx [NCH];
  logic [31:0] hist_model, seed, rnd;
  logic [7:0] disp_seg [8];
  logic [15:0] frame;
  logic all_low_seen, held;

  periph_top dut_i (
    .sys_clk(sys_clk), .rst(rst), .cmd(cmd), .cmd_valid(cmd_valid),
    .cmd_ready(cmd_ready), .resp(resp), .resp_valid(resp_valid),
    .resp_ready(resp_ready), .spi_miso(spi_miso), .spi_mosi(spi_mosi),
    .spi_sclk(spi_sclk), .spi_cs(spi_cs), .segled_clk(segled_clk),
    .segled_dat(segled_dat), .segled_str(segled_str)
  );

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERROR at %0t: %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  initial begin
    sys_clk = 1'b0;
    forever #4 sys_clk = ~sys_clk;
  end

  // resp_ready held low for the file stalls and random otherwise
  always @(posedge sys_clk) begin
    if (stall_used < stall_total) begin
      resp_ready <= 1'b0;
      stall_used <= stall_used + 1;
    end else begin
      rnd = $random(seed);
      resp_ready <= (rnd[1:0] != 2'b00);
    end
  end

  // spi slave model for each lane
  always @(posedge sys_clk) begin
    sclk_d <= spi_sclk;
    cs_d   <= spi_cs;
    if (spi_cs == '0) all_low_seen <= 1'b1;
    for (int c = 0; c < NCH; c++) begin
      if (!rst && cs_d[c] && !spi_cs[c]) begin
        if (sl_rd[c] < wr[c]) begin
          cur_ln[c] = chan_line[c][sl_rd[c]];
          tx[c] = miso_v[cur_ln[c]];
          bitn[c] = 0;
          spi_miso[c] <= tx[c][7];
        end else begin
          $display("chip select of channel %0d went low with no command for it", c);
          errors++;
        end
      end
      if (!spi_cs[c] && spi_sclk[c] && !sclk_d[c]) begin
        rx[c] = {rx[c][6:0], spi_mosi[c]};  // mode 0 capture
        bitn[c]++;
      end
      if (!spi_cs[c] && !spi_sclk[c] && sclk_d[c] && bitn[c] < 8) begin
        spi_miso[c] <= tx[c][7 - bitn[c]];
      end
      if (!rst && !cs_d[c] && spi_cs[c] && sl_rd[c] < wr[c]) begin
        check($sformatf("spi_mosi[%0d]", c), rx[c], mosi_v[cur_ln[c]]);
        check($sformatf("sclk_count[%0d]", c), bitn[c], 8);
        sl_rd[c]++;
      end
    end
  end

  // response monitor
  always @(posedge sys_clk) begin
    held <= resp_valid && !resp_ready;
    resp_prev <= resp;
    if (!rst && held) check("resp_stable", resp, resp_prev);
    if (!rst && resp_valid && resp_ready) begin
      if (resp.ch >= NCH || rsp_rd[resp.ch] >= wr[resp.ch]) begin
        $display("response from channel %0d arrived with nothing pending", resp.ch);
        errors++;
      end else begin
        check("resp.data", resp.data, miso_v[chan_line[resp.ch][rsp_rd[resp.ch]]]);
        hist_model = {hist_model[23:0], miso_v[chan_line[resp.ch][rsp_rd[resp.ch]]]};
        rsp_rd[resp.ch]++;
      end
      resp_cnt++;
    end
  end

  // 74hc595 frame decoder
  always @(posedge sys_clk) begin
    seg_clk_d <= segled_clk;
    seg_str_d <= segled_str;
    if (segled_clk && !seg_clk_d) frame = {frame[14:0], segled_dat};
    if (segled_str && !seg_str_d) begin
      if ($onehot(frame[7:0])) begin
        for (int k = 0; k < 8; k++) begin
          if (frame[k]) disp_seg[k] = frame[15:8];
        end
      end else begin
        $display("display frame carried a digit select that is not one-hot");
        errors++;
      end
      frame_cnt++;
    end
  end

  initial begin
    int fd, n, cnt, e0, f0;
    string line;
    logic [7:0] a, b, c;
    int s;
    seed = 32'hbc3a_539a;
    rst = 1'b1;
    cmd = '0;
    cmd_valid = 1'b0;
    resp_ready = 1'b0;
    spi_miso = '0;
    hist_model = '0;
    all_low_seen = 1'b0;
    nlines = 0;
    n_exp = 0;
    errors = 0;
    fd = $fopen("sim/periph_stim.txt", "r");
    if (fd == 0) begin
      $display("could not open the stimulus file");
      errors++;
    end else begin
      while (!$feof(fd)) begin
        n = $fgets(line, fd);
        if (n > 1 && line[0] != "#") begin
          n = $sscanf(line, "%h %h %h %d", a, b, c, s);
          if (n == 4 && nlines < MAXL) begin
            ch_v[nlines] = a[1:0];
            mosi_v[nlines] = b;
            miso_v[nlines] = c;
            stall_v[nlines] = s;
            if (a < NCH) n_exp++;
            nlines++;
          end
        end
      end
      $fclose(fd);
    end
    repeat (10) @(posedge sys_clk);
    rst <= 1'b0;

    // transfers, responses and stalls
    e0 = errors;
    for (int i = 0; i < nlines; i++) begin
      cmd <= '{ch: ch_v[i], data: mosi_v[i]};
      cmd_valid <= 1'b1;
      cnt = 0;
      do begin
        @(posedge sys_clk);
        cnt++;
      end while (!cmd_ready && cnt < 5000);
      if (!cmd_ready) begin
        $display("command %0d was never accepted", i);
        errors++;
      end else if (ch_v[i] < NCH) begin
        chan_line[ch_v[i]][wr[ch_v[i]]] = i;
        wr[ch_v[i]]++;
      end
      stall_total <= stall_total + stall_v[i];
    end
    cmd_valid <= 1'b0;
    cnt = 0;
    while (resp_cnt < n_exp && cnt < 50000) begin
      @(posedge sys_clk);
      cnt++;
    end
    if (resp_cnt < n_exp) begin
      $display("only %0d of %0d responses arrived in time", resp_cnt, n_exp);
      errors++;
    end
    $display("test transfers: %0d responses, %0d errors", resp_cnt, errors - e0);

    // channel 3 leaves no trace
    e0 = errors;
    repeat (200) @(posedge sys_clk);
    check("resp_count", resp_cnt, n_exp);
    for (int k = 0; k < NCH; k++) check($sformatf("cs_count[%0d]", k), sl_rd[k], wr[k]);
    $display("test dropped channel: %0d errors", errors - e0);

    // overlap of all three lanes
    e0 = errors;
    check("all_cs_low_seen", all_low_seen, 1'b1);
    $display("test overlap: %0d errors", errors - e0);

    // display shows the last four bytes
    e0 = errors;
    f0 = frame_cnt;
    cnt = 0;
    while (frame_cnt < f0 + 9 && cnt < 5000) begin
      @(posedge sys_clk);
      cnt++;
    end
    if (frame_cnt < f0 + 9) begin
      $display("display frames stopped arriving");
      errors++;
    end
    for (int k = 0; k < 8; k++) begin
      check($sformatf("digit[%0d]", k), disp_seg[k], hex_to_seg(hist_model[4*k +: 4]));
    end
    $display("test display: %0d errors", errors - e0);

    $display("summary: %0d lines, %0d responses, %0d errors", nlines, resp_cnt, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  initial begin
    stall_total = 0;
    stall_used = 0;
    resp_cnt = 0;
    frame_cnt = 0;
    for (int c = 0; c < NCH; c++) begin
      wr[c] = 0;
      sl_rd[c] = 0;
      rsp_rd[c] = 0;
      bitn[c] = 0;
    end
  end

endmodule

/* sim/periph_stim.txt */
# ch mosi miso stall   (hex hex hex decimal)
# stall = extra cycles of resp_ready low after the command is accepted
0 a5 3c 0
1 5a c3 0
2 ff 00 0
0 01 80 5
1 80 01 0
2 12 34 40
3 77 88 0
0 de ad 0
1 be ef 0
2 ca fe 0
0 00 ff 100
1 0f f0 0
2 f0 0f 3
3 11 22 0
0 55 aa 0
0 aa 55 0
1 13 57 0
1 24 68 60
2 9b df 0
2 e1 7c 0
0 42 24 0
1 c8 8c 7
2 3e e3 0
0 69 96 0
1 b4 4b 20
2 2d d2 0
0 81 18 0
2 76 67 0
1 12 9a 0

/* flist.f */
+incdir+common
common/periph_pkg.sv
softspi/spi_cmd_dispatch.sv
softspi/spi_channel.sv
softspi/spi_resp_collect.sv
source/seg_led_hex595.sv
source/periph_top.sv
sim/periph_props.sv
sim/periph_tb.sv

/* Bender.yml */
package:
  name: soft_spi_periph

export_include_dirs:
  - common

sources:
  - common/periph_pkg.sv
  - softspi/spi_cmd_dispatch.sv
  - softspi/spi_channel.sv
  - softspi/spi_resp_collect.sv
  - source/seg_led_hex595.sv
  - source/periph_top.sv
  - target: simulation
    files:
      - sim/periph_props.sv
      - sim/periph_tb.sv
